/* common/dcache_pkg.sv */
// Data cache package with geometry constants and the shared request, refill and tag types
`default_nettype none

package dcache_pkg;

   // Address and word geometry
   localparam int ADDR_WIDTH     = 32;
   localparam int DATA_WIDTH     = 32;
   localparam int BYTES_PER_WORD = DATA_WIDTH / 8;

   // Cache geometry, 16 sets of four-word lines
   localparam int SET_WIDTH      = 4;
   localparam int BLOCK_WIDTH    = 4;
   localparam int WORD_SEL_WIDTH = BLOCK_WIDTH - 2;
   localparam int TAG_WIDTH      = ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;

   // Set plus word index, the address of a data way memory
   localparam int WORD_ADDR_WIDTH = SET_WIDTH + WORD_SEL_WIDTH;

   // Way numbers, enough for up to eight ways
   localparam int WAY_NUM_WIDTH = 3;

   typedef logic [DATA_WIDTH-1:0]      word_t;
   typedef logic [SET_WIDTH-1:0]       set_idx_t;
   typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;

   // Whole CPU request, held by the CPU until the acknowledge
   typedef struct packed {
      logic [ADDR_WIDTH-1:0]     addr;
      logic                      we;
      logic [BYTES_PER_WORD-1:0] bsel;
      word_t                     wdata;
   } cpu_req_t;

   // One word returning from the refill bus
   typedef struct packed {
      logic [WORD_SEL_WIDTH-1:0] offset;
      word_t                     data;
   } refill_word_t;

   // Tag entry of a single way
   typedef struct packed {
      logic                 valid;
      logic [TAG_WIDTH-1:0] tag;
   } tag_way_t;

   typedef enum logic [2:0] {
      TAG_NONE,
      TAG_TOUCH,
      TAG_KILL_WAY,
      TAG_FILL,
      TAG_CLEAR_SET
   } tag_op_e;

   // Tag store operation issued by the controller
   typedef struct packed {
      tag_op_e                  op;
      set_idx_t                 set;
      logic [WAY_NUM_WIDTH-1:0] way;
      logic [TAG_WIDTH-1:0]     tag;
   } tag_op_t;

endpackage

`default_nettype wire

/* logic/dcache_ram.sv */
// Simple dual-port memory with registered read, entry type chosen by parameter
`default_nettype none
`timescale 1ns/10ps

module dcache_ram #(
   parameter type entry_t   = logic [31:0],
   parameter int  ADDR_BITS = 4
) (
   input  wire logic                 clk,
   input  wire logic [ADDR_BITS-1:0] raddr_i,
   input  wire logic [ADDR_BITS-1:0] waddr_i,
   input  wire logic                 we_i,
   input  wire entry_t               wdata_i,
   output entry_t                    rdata_o
);

   // Storage, contents undefined until written
   entry_t mem [2**ADDR_BITS];

   // Read sees the old entry when both ports hit the same address
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
      rdata_o <= mem[raddr_i];
   end

endmodule

`default_nettype wire

/* dcache/dcache_lru.sv */
// Matrix LRU for any way count, updates the pair history and picks the oldest way
`default_nettype none
`timescale 1ns/10ps

module dcache_lru #(
   parameter  int NUM_WAYS = 2,
   localparam int LRU_W    = (NUM_WAYS > 1) ? NUM_WAYS * (NUM_WAYS - 1) / 2 : 1
) (
   input  wire logic [LRU_W-1:0]    history_i,
   input  wire logic [NUM_WAYS-1:0] access_i,
   output logic [LRU_W-1:0]         history_o,
   output logic [NUM_WAYS-1:0]      victim_o
);

   // One bit per pair (i, j) with i < j
   // Bit low means way i is the older one of the pair
   // Cleared history therefore makes way 0 the victim
   always_comb begin
      int unsigned idx;
      idx = 0;
      history_o = history_i;
      // Every way starts as a candidate and is struck out by a newer pair bit
      victim_o = '1;
      for (int i = 0; i < NUM_WAYS; i++) begin
         for (int j = i + 1; j < NUM_WAYS; j++) begin
            // Accessed way becomes newer than its partner
            if (access_i[i]) begin
               history_o[idx] = 1'b1;
            end
            if (access_i[j]) begin
               history_o[idx] = 1'b0;
            end
            // Newer way of the pair cannot be the victim
            if (history_i[idx]) begin
               victim_o[i] = 1'b0;
            end else begin
               victim_o[j] = 1'b0;
            end
            idx++;
         end
      end
   end

endmodule

`default_nettype wire

/* dcache/dcache_tag_store.sv */
// Tag store with per-way hit compare, LRU victim and read-modify-write tag operations
`default_nettype none
`timescale 1ns/10ps

module dcache_tag_store #(
   parameter  int NUM_WAYS = 2,
   localparam int LRU_W    = (NUM_WAYS > 1) ? NUM_WAYS * (NUM_WAYS - 1) / 2 : 1
) (
   input  wire logic                            clk,
   input  wire dcache_pkg::set_idx_t            lookup_set_i,
   input  wire logic [dcache_pkg::TAG_WIDTH-1:0] lookup_tag_i,
   input  wire dcache_pkg::tag_op_t             tag_op_i,
   output logic [NUM_WAYS-1:0]                  hit_way_o,
   output logic [NUM_WAYS-1:0]                  victim_o
);

   import dcache_pkg::*;

   // One memory word per set, LRU history above the way entries
   typedef struct packed {
      logic [LRU_W-1:0]            lru;
      tag_way_t [NUM_WAYS-1:0]     ways;
   } tag_entry_t;

   tag_entry_t          rd_entry;
   tag_entry_t          wr_entry;
   logic                tag_we;
   logic [NUM_WAYS-1:0] way_sel;
   logic [NUM_WAYS-1:0] access;
   logic [LRU_W-1:0]    lru_next;

   dcache_ram #(
      .entry_t   (tag_entry_t),
      .ADDR_BITS (SET_WIDTH)
   ) u_tag_ram (
      .clk     (clk),
      .raddr_i (lookup_set_i),
      .waddr_i (tag_op_i.set),
      .we_i    (tag_we),
      .wdata_i (wr_entry),
      .rdata_o (rd_entry)
   );

   dcache_lru #(
      .NUM_WAYS (NUM_WAYS)
   ) u_lru (
      .history_i (rd_entry.lru),
      .access_i  (access),
      .history_o (lru_next),
      .victim_o  (victim_o)
   );

   // Hit compare and one-hot decode of the operation's way number
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         hit_way_o[w] = rd_entry.ways[w].valid && (rd_entry.ways[w].tag == lookup_tag_i);
         way_sel[w]   = (tag_op_i.way == WAY_NUM_WIDTH'(w));
      end
   end

   // Operations modify the entry read at the lookup set
   always_comb begin
      wr_entry = rd_entry;
      tag_we   = 1'b0;
      access   = '0;
      case (tag_op_i.op)
         TAG_TOUCH: begin
            access       = way_sel;
            wr_entry.lru = lru_next;
            tag_we       = 1'b1;
         end
         TAG_KILL_WAY: begin
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (way_sel[w]) begin
                  wr_entry.ways[w].valid = 1'b0;
               end
            end
            tag_we = 1'b1;
         end
         TAG_FILL: begin
            for (int w = 0; w < NUM_WAYS; w++) begin
               if (way_sel[w]) begin
                  wr_entry.ways[w] = '{valid: 1'b1, tag: tag_op_i.tag};
               end
            end
            // Fill counts as an access of the filled way
            access       = way_sel;
            wr_entry.lru = lru_next;
            tag_we       = 1'b1;
         end
         TAG_CLEAR_SET: begin
            wr_entry = '0;
            tag_we   = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

/* dcache/dcache_data_array.sv */
// Data way memories with hit-way read select and byte-merged CPU writes
`default_nettype none
`timescale 1ns/10ps

module dcache_data_array #(
   parameter int NUM_WAYS = 2
) (
   input  wire logic                                   clk,
   input  wire dcache_pkg::word_addr_t                 raddr_i,
   input  wire dcache_pkg::word_addr_t                 waddr_i,
   input  wire logic [NUM_WAYS-1:0]                    way_we_i,
   input  wire logic                                   fill_i,
   input  wire dcache_pkg::word_t                      refill_data_i,
   input  wire dcache_pkg::word_t                      cpu_wdata_i,
   input  wire logic [dcache_pkg::BYTES_PER_WORD-1:0]  bsel_i,
   input  wire logic [NUM_WAYS-1:0]                    hit_way_i,
   output dcache_pkg::word_t                           rdata_o
);

   import dcache_pkg::*;

   word_t way_rdata [NUM_WAYS];
   word_t merged;
   word_t wdata;

   // All ways share address and write data, only the enable differs
   for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
      dcache_ram #(
         .entry_t   (word_t),
         .ADDR_BITS (WORD_ADDR_WIDTH)
      ) u_way_ram (
         .clk     (clk),
         .raddr_i (raddr_i),
         .waddr_i (waddr_i),
         .we_i    (way_we_i[g]),
         .wdata_i (wdata),
         .rdata_o (way_rdata[g])
      );
   end

   // AND-OR select of the hit way, zero on a miss
   always_comb begin
      rdata_o = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (hit_way_i[w]) begin
            rdata_o = rdata_o | way_rdata[w];
         end
      end
   end

   // Unselected bytes keep the word read during lookup
   always_comb begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         merged[8*b +: 8] = bsel_i[b] ? cpu_wdata_i[8*b +: 8] : rdata_o[8*b +: 8];
      end
   end

   // Refill words go in unchanged
   assign wdata = fill_i ? refill_data_i : merged;

endmodule

`default_nettype wire

/* dcache/dcache_ctrl.sv */
// Data cache controller sequencing lookups, line refills and set invalidates
`default_nettype none
`timescale 1ns/10ps

module dcache_ctrl #(
   parameter int NUM_WAYS = 2
) (
   input  wire logic                                  clk,
   input  wire logic                                  rst,
   input  wire logic                                  cpu_req_i,
   input  wire dcache_pkg::cpu_req_t                  cpu_req_data_i,
   input  wire logic                                  refill_we_i,
   input  wire dcache_pkg::refill_word_t              refill_word_i,
   input  wire logic                                  inv_i,
   input  wire dcache_pkg::set_idx_t                  inv_set_i,
   input  wire logic [NUM_WAYS-1:0]                   hit_way_i,
   input  wire logic [NUM_WAYS-1:0]                   victim_i,
   output dcache_pkg::tag_op_t                        tag_op_o,
   output logic [NUM_WAYS-1:0]                        way_we_o,
   output logic                                       fill_o,
   output dcache_pkg::word_addr_t                     waddr_o,
   output logic                                       cpu_ack_o,
   output logic                                       cpu_hit_o,
   output logic                                       refill_req_o,
   output logic [dcache_pkg::ADDR_WIDTH-1:0]          refill_adr_o,
   output logic                                       inv_ack_o
);

   import dcache_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      REFILL
   } state_e;

   state_e                    state;
   logic [NUM_WAYS-1:0]       victim_q;
   logic [WORD_SEL_WIDTH-1:0] word_cnt;
   logic                      hit;
   logic                      first_word;
   logic                      last_word;
   set_idx_t                  req_set;
   logic [TAG_WIDTH-1:0]      req_tag;

   // One-hot way vector to way number
   function automatic logic [WAY_NUM_WIDTH-1:0] way_num(input logic [NUM_WAYS-1:0] onehot);
      logic [WAY_NUM_WIDTH-1:0] num;
      num = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (onehot[w]) begin
            num = num | WAY_NUM_WIDTH'(w);
         end
      end
      return num;
   endfunction

   assign req_set    = cpu_req_data_i.addr[BLOCK_WIDTH +: SET_WIDTH];
   assign req_tag    = cpu_req_data_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
   assign hit        = |hit_way_i;
   // Bus returns words in order, so the count tells first and last
   assign first_word = (word_cnt == '0);
   assign last_word  = &word_cnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         word_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               // Invalidate wins over a pending request
               if (!inv_i && cpu_req_i) begin
                  state <= LOOKUP;
               end
            end
            LOOKUP: begin
               word_cnt <= '0;
               // Hits and all writes finish here, read misses go refill
               if (hit || cpu_req_data_i.we) begin
                  state <= IDLE;
               end else begin
                  state <= REFILL;
               end
            end
            REFILL: begin
               if (refill_we_i) begin
                  word_cnt <= word_cnt + 1'b1;
                  // Back to IDLE for a fresh lookup of the filled line
                  if (last_word) begin
                     state <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Victim held for the whole refill
   always_ff @(posedge clk) begin
      if (state == LOOKUP && !hit && !cpu_req_data_i.we) begin
         victim_q <= victim_i;
      end
   end

   // Tag operation and way write enables per state
   always_comb begin
      tag_op_o = '{op: TAG_NONE, set: req_set, way: '0, tag: req_tag};
      way_we_o = '0;
      case (state)
         IDLE: begin
            if (inv_i) begin
               tag_op_o.op  = TAG_CLEAR_SET;
               tag_op_o.set = inv_set_i;
            end
         end
         LOOKUP: begin
            if (hit) begin
               tag_op_o.op  = TAG_TOUCH;
               tag_op_o.way = way_num(hit_way_i);
               // Write hit merges into the hit way
               if (cpu_req_data_i.we) begin
                  way_we_o = hit_way_i;
               end
            end
         end
         REFILL: begin
            if (refill_we_i) begin
               way_we_o     = victim_q;
               tag_op_o.way = way_num(victim_q);
               // Victim goes invalid on the first word, valid again on the last
               if (first_word) begin
                  tag_op_o.op = TAG_KILL_WAY;
               end else if (last_word) begin
                  tag_op_o.op = TAG_FILL;
               end
            end
         end
         default: begin
         end
      endcase
   end

   // Refill writes land at the returned offset
   assign waddr_o = (state == REFILL) ? {req_set, refill_word_i.offset}
                                      : cpu_req_data_i.addr[BLOCK_WIDTH+SET_WIDTH-1:2];
   assign fill_o       = (state == REFILL);
   assign cpu_ack_o    = (state == LOOKUP) && cpu_req_i && (hit || cpu_req_data_i.we);
   assign cpu_hit_o    = cpu_ack_o && hit;
   assign refill_req_o = (state == REFILL);
   assign refill_adr_o = {cpu_req_data_i.addr[ADDR_WIDTH-1:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};
   assign inv_ack_o    = (state == IDLE) && inv_i;

endmodule

`default_nettype wire

/* dcache/dcache_top.sv */
// Data cache top level joining controller, tag store and data ways
`default_nettype none
`timescale 1ns/10ps

module dcache_top #(
   parameter int NUM_WAYS = 2
) (
   input  wire logic                             clk,
   input  wire logic                             rst,
   input  wire logic                             cpu_req_i,
   input  wire dcache_pkg::cpu_req_t             cpu_req_data_i,
   output logic                                  cpu_ack_o,
   output logic                                  cpu_hit_o,
   output dcache_pkg::word_t                     cpu_rdata_o,
   output logic                                  refill_req_o,
   output logic [dcache_pkg::ADDR_WIDTH-1:0]     refill_adr_o,
   input  wire logic                             refill_we_i,
   input  wire dcache_pkg::refill_word_t         refill_word_i,
   input  wire logic                             inv_i,
   input  wire dcache_pkg::set_idx_t             inv_set_i,
   output logic                                  inv_ack_o
);

   import dcache_pkg::*;

   set_idx_t             lookup_set;
   logic [TAG_WIDTH-1:0] lookup_tag;
   word_addr_t           data_raddr;
   word_addr_t           data_waddr;
   tag_op_t              tag_op;
   logic [NUM_WAYS-1:0]  hit_way;
   logic [NUM_WAYS-1:0]  victim;
   logic [NUM_WAYS-1:0]  way_we;
   logic                 fill;

   // Both memories read straight from the held request address
   assign lookup_set = cpu_req_data_i.addr[BLOCK_WIDTH +: SET_WIDTH];
   assign lookup_tag = cpu_req_data_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
   assign data_raddr = cpu_req_data_i.addr[BLOCK_WIDTH+SET_WIDTH-1:2];

   dcache_ctrl #(
      .NUM_WAYS (NUM_WAYS)
   ) u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_req_data_i (cpu_req_data_i),
      .refill_we_i    (refill_we_i),
      .refill_word_i  (refill_word_i),
      .inv_i          (inv_i),
      .inv_set_i      (inv_set_i),
      .hit_way_i      (hit_way),
      .victim_i       (victim),
      .tag_op_o       (tag_op),
      .way_we_o       (way_we),
      .fill_o         (fill),
      .waddr_o        (data_waddr),
      .cpu_ack_o      (cpu_ack_o),
      .cpu_hit_o      (cpu_hit_o),
      .refill_req_o   (refill_req_o),
      .refill_adr_o   (refill_adr_o),
      .inv_ack_o      (inv_ack_o)
   );

   dcache_tag_store #(
      .NUM_WAYS (NUM_WAYS)
   ) u_tag_store (
      .clk          (clk),
      .lookup_set_i (lookup_set),
      .lookup_tag_i (lookup_tag),
      .tag_op_i     (tag_op),
      .hit_way_o    (hit_way),
      .victim_o     (victim)
   );

   dcache_data_array #(
      .NUM_WAYS (NUM_WAYS)
   ) u_data_array (
      .clk           (clk),
      .raddr_i       (data_raddr),
      .waddr_i       (data_waddr),
      .way_we_i      (way_we),
      .fill_i        (fill),
      .refill_data_i (refill_word_i.data),
      .cpu_wdata_i   (cpu_req_data_i.wdata),
      .bsel_i        (cpu_req_data_i.bsel),
      .hit_way_i     (hit_way),
      .rdata_o       (cpu_rdata_o)
   );

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
// Data cache testbench with random requests against memory, tag and LRU models
`default_nettype none
`timescale 1ns/10ps

module dcache_tb;

   import dcache_pkg::*;

   localparam int NUM_WAYS = 2;
   localparam int NUM_SETS = 2**SET_WIDTH;
   localparam int TIMEOUT  = 200;
   // Lines sit above this base with 64 lines over 16 sets
   localparam logic [ADDR_WIDTH-1:0] BASE_ADDR = 32'h0001_0000;

   logic                  clk;
   logic                  rst;
   logic                  cpu_req;
   cpu_req_t              cpu_req_data;
   logic                  cpu_ack;
   logic                  cpu_hit;
   word_t                 cpu_rdata;
   logic                  refill_req;
   logic [ADDR_WIDTH-1:0] refill_adr;
   logic                  refill_we;
   refill_word_t          refill_word;
   logic                  inv;
   set_idx_t              inv_set;
   logic                  inv_ack;

   // Sparse backing memory keyed by word-aligned address
   word_t                mem_model [word_t];
   // Tag and LRU model
   // victim_model holds the older way of each set
   logic [TAG_WIDTH-1:0] tag_model [NUM_SETS][NUM_WAYS];
   logic                 valid_model [NUM_SETS][NUM_WAYS];
   int                   victim_model [NUM_SETS];

   logic [15:0] lfsr;
   int          errors;
   int          requests;
   int          refills;
   int          invals;
   int          inv_pulses = 0;
   logic        hung;

   dcache_top #(
      .NUM_WAYS (NUM_WAYS)
   ) u_dcache_top (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req),
      .cpu_req_data_i (cpu_req_data),
      .cpu_ack_o      (cpu_ack),
      .cpu_hit_o      (cpu_hit),
      .cpu_rdata_o    (cpu_rdata),
      .refill_req_o   (refill_req),
      .refill_adr_o   (refill_adr),
      .refill_we_i    (refill_we),
      .refill_word_i  (refill_word),
      .inv_i          (inv),
      .inv_set_i      (inv_set),
      .inv_ack_o      (inv_ack)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Every clock edge that sees the invalidate acknowledge counts as one pulse
   always @(posedge clk) begin
      if (inv_ack) begin
         inv_pulses++;
      end
   end

   // Galois LFSR stepped once for every bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return r;
   endfunction

   // Unwritten words follow from the whole address
   function automatic word_t mem_read(input logic [ADDR_WIDTH-1:0] addr);
      word_t key;
      key = {addr[ADDR_WIDTH-1:2], 2'b00};
      if (mem_model.exists(key)) begin
         return mem_model[key];
      end
      return ~key ^ {key[15:0], key[31:16]} ^ 32'h5A3C_96E1;
   endfunction

   function automatic void mem_write(input logic [ADDR_WIDTH-1:0] addr,
                                     input logic [BYTES_PER_WORD-1:0] bsel, input word_t wdata);
      word_t merged;
      merged = mem_read(addr);
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         if (bsel[b]) begin
            merged[8*b +: 8] = wdata[8*b +: 8];
         end
      end
      mem_model[{addr[ADDR_WIDTH-1:2], 2'b00}] = merged;
   endfunction

   // Way holding the line or -1 on a miss
   function automatic int model_lookup(input logic [ADDR_WIDTH-1:0] addr);
      int way;
      way = -1;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (valid_model[addr[BLOCK_WIDTH +: SET_WIDTH]][w] &&
             tag_model[addr[BLOCK_WIDTH +: SET_WIDTH]][w] == addr[ADDR_WIDTH-1 -: TAG_WIDTH]) begin
            way = w;
         end
      end
      return way;
   endfunction

   // Four tag variants per set give the 64 lines
   function automatic logic [ADDR_WIDTH-1:0] line_addr(input set_idx_t s, input logic [1:0] tsel);
      return BASE_ADDR | ADDR_WIDTH'({tsel, s, 4'b0000});
   endfunction

   function automatic logic [ADDR_WIDTH-1:0] rand_addr();
      set_idx_t   s;
      logic [1:0] tsel;
      logic [1:0] word;
      s    = set_idx_t'(rand_bits(4));
      tsel = 2'(rand_bits(2));
      word = 2'(rand_bits(2));
      return line_addr(s, tsel) | ADDR_WIDTH'({word, 2'b00});
   endfunction

   task automatic report_mismatch(input string name, input word_t got, input word_t exp);
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
      errors++;
   endtask

   task automatic report_error(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      errors++;
   endtask

   task automatic end_test(input string name, input int err_mark);
      $display("%s finished with %0d errors", name, errors - err_mark);
   endtask

   // Refill bus returning words in order with 0 to 3 idle cycles before each
   task automatic serve_refill(input logic [ADDR_WIDTH-1:0] base);
      int gap;
      for (int o = 0; o < 4; o++) begin
         gap = int'(rand_bits(2));
         repeat (gap) @(negedge clk);
         if (!refill_req) begin
            report_error($sformatf("refill request dropped before word %0d", o));
         end
         refill_we   = 1'b1;
         refill_word = '{offset: WORD_SEL_WIDTH'(o), data: mem_read(base | ADDR_WIDTH'(4 * o))};
         @(negedge clk);
         refill_we = 1'b0;
      end
   endtask

   // One CPU request checked against the models with any refill served on the way
   task automatic cpu_access(input logic [ADDR_WIDTH-1:0] addr, input logic we,
                             input logic [BYTES_PER_WORD-1:0] bsel, input word_t wdata,
                             output logic evicted, output logic [ADDR_WIDTH-1:0] evicted_addr);
      set_idx_t              set;
      logic [TAG_WIDTH-1:0]  tag;
      logic [ADDR_WIDTH-1:0] line;
      int                    hit_way;
      int                    victim;
      int                    cycles;
      logic                  refilled;
      logic                  exp_hit;
      set          = addr[BLOCK_WIDTH +: SET_WIDTH];
      tag          = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
      line         = {addr[ADDR_WIDTH-1:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};
      hit_way      = model_lookup(addr);
      victim       = victim_model[set];
      // Reads always end in a hit while writes only hit when the line is cached
      exp_hit      = we ? (hit_way >= 0) : 1'b1;
      evicted      = !we && hit_way < 0 && valid_model[set][victim];
      evicted_addr = {tag_model[set][victim], set, {BLOCK_WIDTH{1'b0}}};
      refilled     = 1'b0;
      cycles       = 0;
      requests++;
      // Request enters IDLE on a fresh cycle
      @(negedge clk);
      // Cache must be idle between requests, also after a write miss
      if (refill_req) begin
         report_error($sformatf("refill request active with no read miss before %h", addr));
      end
      cpu_req      = 1'b1;
      cpu_req_data = '{addr: addr, we: we, bsel: bsel, wdata: wdata};
      @(negedge clk);
      while (!cpu_ack && cycles < TIMEOUT) begin
         if (refill_req && !refilled) begin
            if (we || hit_way >= 0) begin
               report_error($sformatf("refill raised for a write or predicted hit at %h", addr));
            end
            if (refill_adr !== line) begin
               report_mismatch("refill_adr_o", refill_adr, line);
            end
            serve_refill(line);
            refilled = 1'b1;
            refills++;
         end else begin
            @(negedge clk);
            cycles++;
         end
      end
      if (!cpu_ack) begin
         report_error($sformatf("no acknowledge within %0d cycles for %h", TIMEOUT, addr));
         hung = 1'b1;
      end else begin
         // Hits and writes acknowledge in the cycle after acceptance
         if ((we || hit_way >= 0) && (cycles != 0 || refilled)) begin
            report_error($sformatf("late acknowledge for %h after %0d cycles", addr, cycles));
         end
         if (!we && hit_way < 0 && !refilled) begin
            report_error($sformatf("read miss at %h finished without a refill", addr));
         end
         if (cpu_hit !== exp_hit) begin
            report_mismatch("cpu_hit_o", 32'(cpu_hit), 32'(exp_hit));
         end
         if (!we && cpu_rdata !== mem_read(addr)) begin
            report_mismatch("cpu_rdata_o", cpu_rdata, mem_read(addr));
         end
      end
      cpu_req = 1'b0;
      // Write-around memory and two-way LRU update
      if (we) begin
         mem_write(addr, bsel, wdata);
      end
      if (hit_way >= 0) begin
         victim_model[set] = 1 - hit_way;
      end else if (!we) begin
         tag_model[set][victim]   = tag;
         valid_model[set][victim] = 1'b1;
         victim_model[set]        = 1 - victim;
      end
   endtask

   task automatic invalidate_set(input set_idx_t set);
      int cycles;
      cycles  = 0;
      inv     = 1'b1;
      inv_set = set;
      #1;
      while (!inv_ack && cycles < TIMEOUT) begin
         @(negedge clk);
         #1;
         cycles++;
      end
      if (!inv_ack) begin
         report_error($sformatf("no invalidate acknowledge for set %0d", set));
         hung = 1'b1;
      end else begin
         invals++;
      end
      // Cleared set makes way 0 the victim
      for (int w = 0; w < NUM_WAYS; w++) begin
         valid_model[set][w] = 1'b0;
      end
      victim_model[set] = 0;
      @(negedge clk);
      inv = 1'b0;
   endtask

   task automatic invalidate_all_sets();
      int                    acks;
      logic                  ev;
      logic [ADDR_WIDTH-1:0] ev_addr;
      acks = inv_pulses;
      for (int s = 0; s < NUM_SETS; s++) begin
         invalidate_set(set_idx_t'(s));
      end
      // Exactly one acknowledge pulse per set
      if (inv_pulses - acks != NUM_SETS) begin
         report_error($sformatf("%0d invalidate acknowledges for 16 sets", inv_pulses - acks));
      end
      // First touch of every set has to refill
      for (int s = 0; s < NUM_SETS && !hung; s++) begin
         cpu_access(line_addr(set_idx_t'(s), 2'd0), 1'b0, '0, '0, ev, ev_addr);
      end
   endtask

   task automatic read_random_lines(input int count);
      logic                  ev;
      logic [ADDR_WIDTH-1:0] ev_addr;
      logic                  ev2;
      logic [ADDR_WIDTH-1:0] ev2_addr;
      for (int i = 0; i < count && !hung; i++) begin
         cpu_access(rand_addr(), 1'b0, '0, '0, ev, ev_addr);
         // Line that was just evicted must miss
         if (ev) begin
            cpu_access(ev_addr, 1'b0, '0, '0, ev2, ev2_addr);
         end
      end
   endtask

   task automatic write_and_read_back(input int count);
      logic [ADDR_WIDTH-1:0]     addr;
      logic [BYTES_PER_WORD-1:0] bsel;
      word_t                     wdata;
      logic                      ev;
      logic [ADDR_WIDTH-1:0]     ev_addr;
      for (int i = 0; i < count && !hung; i++) begin
         addr  = rand_addr();
         bsel  = BYTES_PER_WORD'(rand_bits(BYTES_PER_WORD));
         wdata = rand_bits(DATA_WIDTH);
         cpu_access(addr, 1'b1, bsel, wdata, ev, ev_addr);
         cpu_access(addr, 1'b0, '0, '0, ev, ev_addr);
      end
   endtask

   task automatic invalidate_during_run(input int rounds);
      set_idx_t              s;
      set_idx_t              other;
      logic                  ev;
      logic [ADDR_WIDTH-1:0] ev_addr;
      for (int r = 0; r < rounds && !hung; r++) begin
         s     = set_idx_t'(rand_bits(SET_WIDTH));
         other = s + 4'd1;
         // Fill both ways of the set and one line of its neighbor
         cpu_access(line_addr(s, 2'd0), 1'b0, '0, '0, ev, ev_addr);
         cpu_access(line_addr(s, 2'd1), 1'b0, '0, '0, ev, ev_addr);
         cpu_access(line_addr(other, 2'd2), 1'b0, '0, '0, ev, ev_addr);
         invalidate_set(s);
         for (int t = 0; t < 4 && !hung; t++) begin
            cpu_access(line_addr(s, 2'(t)), 1'b0, '0, '0, ev, ev_addr);
         end
         // Neighbor line still cached
         cpu_access(line_addr(other, 2'd2), 1'b0, '0, '0, ev, ev_addr);
      end
   endtask

   task automatic mixed_traffic(input int count);
      logic [ADDR_WIDTH-1:0]     addr;
      logic [3:0]                kind;
      logic [BYTES_PER_WORD-1:0] bsel;
      word_t                     wdata;
      logic                      ev;
      logic [ADDR_WIDTH-1:0]     ev_addr;
      for (int i = 0; i < count && !hung; i++) begin
         addr  = rand_addr();
         kind  = 4'(rand_bits(4));
         bsel  = BYTES_PER_WORD'(rand_bits(BYTES_PER_WORD));
         wdata = rand_bits(DATA_WIDTH);
         // Rare invalidates with a quarter writes and the rest reads
         if (kind == 4'd0) begin
            invalidate_set(addr[BLOCK_WIDTH +: SET_WIDTH]);
         end else if (kind < 4'd5) begin
            cpu_access(addr, 1'b1, bsel, wdata, ev, ev_addr);
         end else begin
            cpu_access(addr, 1'b0, '0, '0, ev, ev_addr);
         end
      end
   endtask

   initial begin
      int err_mark;
      rst          = 1'b1;
      cpu_req      = 1'b0;
      cpu_req_data = '0;
      refill_we    = 1'b0;
      refill_word  = '0;
      inv          = 1'b0;
      inv_set      = '0;
      lfsr         = 16'd18904;
      errors       = 0;
      requests     = 0;
      refills      = 0;
      invals       = 0;
      hung         = 1'b0;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      if (cpu_ack || refill_req || inv_ack) begin
         report_error("acknowledge or refill request active right after reset");
      end
      err_mark = errors;
      invalidate_all_sets();
      end_test("invalidate all sets", err_mark);
      err_mark = errors;
      read_random_lines(200);
      end_test("random reads", err_mark);
      err_mark = errors;
      write_and_read_back(150);
      end_test("random writes with readback", err_mark);
      err_mark = errors;
      invalidate_during_run(6);
      end_test("invalidate mid-run", err_mark);
      err_mark = errors;
      mixed_traffic(400);
      end_test("mixed traffic", err_mark);
      $display("requests %0d, refills %0d, invalidates %0d, errors %0d",
               requests, refills, invals, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
common/dcache_pkg.sv
logic/dcache_ram.sv
dcache/dcache_lru.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_array.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
verification/dcache_tb.sv

/* Makefile */
SIM  := obj_dir/Vdcache_tb
SRCS := $(filter-out +%,$(shell cat compile.f))

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing -f compile.f --top-module dcache_tb -Mdir obj_dir

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
